/* tb.f */
+incdir+sim
common/xlat_pkg.sv
logic/wait_state_seq.sv
logic/read_valid_pipe.sv
logic/slave_xlat.sv
sim/tb_slave_xlat.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_slave_xlat
FILELIST = tb.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# pass only when the testbench prints its pass line
run: compile
	@out=$$(./$(BIN) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST OK$$'

clean:
	rm -rf $(OBJ_DIR)

/* sim/tb_tasks.svh */
// tasks included in the bridge testbench top for checks, lfsr, bus transfers and directed tests
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// --------------------------------------------------
// helpers
// --------------------------------------------------
task automatic compare_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
   if (got !== exp) begin
      fail_run($sformatf("MISMATCH at %0t ns: %s got 0x%h, expected 0x%h",
                         $time, name, got, exp));
   end
endtask

// fibonacci lfsr with taps 32 22 2 1 and one step per bit
function automatic logic [31:0] lfsr_bits(input int n);
   logic [31:0] r;
   logic        fb;
   r = '0;
   for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r          = {r[30:0], fb};
   end
   return r;
endfunction

function automatic logic [31:0] fill_word(input int idx);
   return {8'h5a, 18'h0, 6'(idx)};   // every word tells its own index
endfunction

// sets bits lo through hi and none when hi < lo
function automatic logic [15:0] cycle_mask(input int lo, input int hi);
   logic [15:0] m;
   m = '0;
   for (int i = lo; i <= hi; i++) begin
      m[i] = 1'b1;
   end
   return m;
endfunction

task automatic load_shadow();
   for (int i = 0; i < 64; i++) begin
      shadow[i] = fill_word(i);
   end
endtask

task automatic release_bus();
   @(negedge clk);
   uav_read       = 1'b0;
   uav_write      = 1'b0;
   uav_byteenable = '0;
endtask

// reads return at a fixed latency, so a short wait empties the pipe
task automatic wait_read_drain();
   repeat (RD_LAT + 1) @(negedge clk);
endtask

// --------------------------------------------------
// one bus transfer held until accepted
// --------------------------------------------------
task automatic run_transfer(input logic wr, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] be);
   logic [15:0] bt_tr;
   logic [15:0] strobe_tr;
   logic [15:0] wait_tr;
   logic        done;
   int          k;
   int          acc;
   int          last_strobe;
   string       strobe_name;
   string       other_name;
   bt_tr     = '0;
   strobe_tr = '0;
   wait_tr   = '0;
   done      = 1'b0;
   k         = 0;
   if (wr) begin
      acc         = SETUP + WR_WAIT + HOLD;
      last_strobe = SETUP + WR_WAIT;
      strobe_name = "av_write";
      other_name  = "av_read";
   end else begin
      acc         = SETUP + RD_WAIT;
      last_strobe = SETUP + RD_WAIT;
      strobe_name = "av_read";
      other_name  = "av_write";
   end
   @(negedge clk);
   uav_address    = addr;
   uav_writedata  = data;
   uav_byteenable = be;
   uav_write      = wr;
   uav_read       = !wr;
   while (!done) begin
      #1;
      bt_tr[k]     = av_begintransfer;
      strobe_tr[k] = wr ? av_write : av_read;
      wait_tr[k]   = uav_waitrequest;
      compare_value("av_address", 32'(av_address), 32'(addr[31:WORD_SHIFT]));
      compare_value("av_writedata", av_writedata, data);
      compare_value("av_byteenable", 32'(av_byteenable), 32'(be));
      compare_value("av_writebyteenable", 32'(av_writebyteenable), wr ? 32'(be) : 32'd0);
      compare_value("av_chipselect", 32'(av_chipselect), 32'd1);
      compare_value(other_name, 32'(wr ? av_read : av_write), 32'd0);
      if (!uav_waitrequest) begin
         done = 1'b1;
      end else if (k == 15) begin
         fail_run("transfer not accepted within 16 cycles");
      end else begin
         k++;
         @(negedge clk);
      end
   end
   mapped_addr = av_address;
   compare_value("accept cycle", 32'(k), 32'(acc));
   compare_value("av_begintransfer trace", 32'(bt_tr), 32'(cycle_mask(0, 0)));
   compare_value({strobe_name, " trace"}, 32'(strobe_tr), 32'(cycle_mask(SETUP, last_strobe)));
   compare_value("uav_waitrequest trace", 32'(wait_tr), 32'(cycle_mask(0, acc - 1)));
   if (wr) begin
      for (int b = 0; b < BYTES_PER_WORD; b++) begin
         if (be[b]) begin
            shadow[addr[7:2]][8*b +: 8] = data[8*b +: 8];
         end
      end
   end else begin
      exp_data_q.push_back(shadow[addr[7:2]]);
      exp_cycle_q.push_back(cycle_cnt + RD_LAT);
   end
endtask

// --------------------------------------------------
// directed tests
// --------------------------------------------------
task automatic check_reset_state();
   #1;
   compare_value("uav_waitrequest", 32'(uav_waitrequest), 32'd1);
   compare_value("av_read", 32'(av_read), 32'd0);
   compare_value("av_write", 32'(av_write), 32'd0);
   compare_value("av_begintransfer", 32'(av_begintransfer), 32'd0);
   compare_value("av_chipselect", 32'(av_chipselect), 32'd0);
   compare_value("uav_readdatavalid", 32'(uav_readdatavalid), 32'd0);
endtask

task automatic write_timing();
   run_transfer(1'b1, 32'h20, lfsr_bits(32), 4'b1111);
   compare_value("av_address", 32'(mapped_addr), 32'd8);
   release_bus();
endtask

task automatic read_timing();
   run_transfer(1'b0, 32'h20, 32'd0, 4'b1111);   // data checked by the monitor
   release_bus();
   wait_read_drain();
endtask

task automatic pipelined_reads();
   for (int i = 0; i < 4; i++) begin
      run_transfer(1'b0, 32'h40 + 32'(4 * i), 32'd0, 4'b1111);   // no idle between
   end
   release_bus();
   wait_read_drain();
endtask

task automatic partial_byte_writes();
   logic [5:0]  words [16];
   logic [31:0] data;
   logic [3:0]  be;
   for (int i = 0; i < 16; i++) begin
      words[i] = 6'(lfsr_bits(6));
      data     = lfsr_bits(32);
      be       = 4'(lfsr_bits(4));
      run_transfer(1'b1, {24'd0, words[i], 2'b00}, data, be);
   end
   release_bus();
   for (int i = 0; i < 16; i++) begin
      run_transfer(1'b0, {24'd0, words[i], 2'b00}, 32'd0, 4'b1111);
   end
   release_bus();
   wait_read_drain();
endtask

`endif

/* sim/tb_slave_xlat.sv */
// testbench top for the bridge with clock, reset, memory model, read monitor and test order
`timescale 1ns/1ns
`default_nettype none

module tb_slave_xlat;

   import xlat_pkg::*;

   localparam int SETUP   = DEF_SETUP_CYCLES;
   localparam int RD_WAIT = DEF_READ_WAIT_CYCLES;
   localparam int WR_WAIT = DEF_WRITE_WAIT_CYCLES;
   localparam int HOLD    = DEF_HOLD_CYCLES;
   localparam int RD_LAT  = DEF_READ_LATENCY;

   // about 40 transfers of under 10 cycles each fit well inside this
   localparam int MAX_CYCLES = 2000;

   logic                      clk;
   logic                      reset;
   logic [UAV_ADDR_W-1:0]     uav_address;
   logic [UAV_DATA_W-1:0]     uav_writedata;
   logic [BYTES_PER_WORD-1:0] uav_byteenable;
   logic                      uav_read;
   logic                      uav_write;
   logic [UAV_DATA_W-1:0]     uav_readdata;
   logic                      uav_readdatavalid;
   logic                      uav_waitrequest;
   logic [AV_ADDR_W-1:0]      av_address;
   logic [UAV_DATA_W-1:0]     av_writedata;
   logic [BYTES_PER_WORD-1:0] av_byteenable;
   logic [BYTES_PER_WORD-1:0] av_writebyteenable;
   logic                      av_read;
   logic                      av_write;
   logic                      av_begintransfer;
   logic                      av_chipselect;
   logic [UAV_DATA_W-1:0]     av_readdata;

   int          cycle_cnt = 0;
   logic [31:0] lfsr_state;
   logic [31:0] shadow [64];         // expected peripheral contents
   logic [31:0] exp_data_q [$];      // reads in flight with the oldest first
   int          exp_cycle_q [$];
   logic [29:0] mapped_addr;         // av_address seen in the last transfer

   logic [31:0]       mem [64];
   logic [RD_LAT-1:0] dly_vld;
   logic [5:0]        dly_addr [RD_LAT];

   slave_xlat #(
      .SETUP_CYCLES     (SETUP),
      .READ_WAIT_CYCLES (RD_WAIT),
      .WRITE_WAIT_CYCLES(WR_WAIT),
      .HOLD_CYCLES      (HOLD),
      .READ_LATENCY     (RD_LAT)
   ) uut (
      .clk               (clk),
      .reset             (reset),
      .uav_address       (uav_address),
      .uav_writedata     (uav_writedata),
      .uav_byteenable    (uav_byteenable),
      .uav_read          (uav_read),
      .uav_write         (uav_write),
      .uav_readdata      (uav_readdata),
      .uav_readdatavalid (uav_readdatavalid),
      .uav_waitrequest   (uav_waitrequest),
      .av_address        (av_address),
      .av_writedata      (av_writedata),
      .av_byteenable     (av_byteenable),
      .av_writebyteenable(av_writebyteenable),
      .av_read           (av_read),
      .av_write          (av_write),
      .av_begintransfer  (av_begintransfer),
      .av_chipselect     (av_chipselect),
      .av_readdata       (av_readdata)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // stops the run with the reason on the line before
   task automatic fail_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped");
   endtask

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == MAX_CYCLES) begin
         fail_run($sformatf("timeout, tests did not finish within %0d cycles", MAX_CYCLES));
      end
   end

   // --------------------------------------------------
   // peripheral model with fixed read latency
   // --------------------------------------------------
   always @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < 64; i++) begin
            mem[i] <= fill_word(i);
         end
      end else if (av_write) begin
         for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (av_writebyteenable[b]) begin
               mem[av_address[5:0]][8*b +: 8] <= av_writedata[8*b +: 8];
            end
         end
      end
   end

   always @(posedge clk or posedge reset) begin
      if (reset) begin
         dly_vld <= '0;
         for (int i = 0; i < RD_LAT; i++) begin
            dly_addr[i] <= '0;
         end
      end else begin
         dly_vld[0]  <= uav_read & ~uav_waitrequest;   // read accepted at this edge
         dly_addr[0] <= av_address[5:0];
         for (int i = 1; i < RD_LAT; i++) begin
            dly_vld[i]  <= dly_vld[i-1];
            dly_addr[i] <= dly_addr[i-1];
         end
      end
   end

   assign av_readdata = dly_vld[RD_LAT-1] ? mem[dly_addr[RD_LAT-1]] : '0;

   // --------------------------------------------------
   // read return monitor
   // --------------------------------------------------
   always begin
      @(negedge clk);
      #1;
      if (!reset) begin
         if (uav_readdatavalid) begin
            if (exp_data_q.size() == 0) begin
               fail_run("readdatavalid seen with no read outstanding");
            end else begin
               compare_value("uav_readdatavalid cycle", 32'(cycle_cnt), 32'(exp_cycle_q[0]));
               compare_value("uav_readdata", uav_readdata, exp_data_q[0]);
               void'(exp_data_q.pop_front());
               void'(exp_cycle_q.pop_front());
            end
         end else if (exp_cycle_q.size() != 0 && cycle_cnt >= exp_cycle_q[0]) begin
            fail_run($sformatf("readdatavalid missing in cycle %0d", exp_cycle_q[0]));
         end
      end
   end

   `include "tb_tasks.svh"

   initial begin
      reset          = 1'b1;
      uav_address    = '0;
      uav_writedata  = '0;
      uav_byteenable = '0;
      uav_read       = 1'b0;
      uav_write      = 1'b0;
      lfsr_state     = 32'hcf09;
      load_shadow();
      repeat (4) @(negedge clk);
      reset = 1'b0;

      check_reset_state();
      write_timing();
      read_timing();
      pipelined_reads();
      partial_byte_writes();

      $display("TEST OK");
      $finish;
   end

endmodule : tb_slave_xlat

`default_nettype wire

/* logic/slave_xlat.sv */
// bridge top: maps a byte-addressed system bus onto a fixed-timing word-addressed peripheral
`timescale 1ns/1ns
`default_nettype none

module slave_xlat #(
   parameter int SETUP_CYCLES      = xlat_pkg::DEF_SETUP_CYCLES,
   parameter int READ_WAIT_CYCLES  = xlat_pkg::DEF_READ_WAIT_CYCLES,
   parameter int WRITE_WAIT_CYCLES = xlat_pkg::DEF_WRITE_WAIT_CYCLES,
   parameter int HOLD_CYCLES       = xlat_pkg::DEF_HOLD_CYCLES,
   parameter int READ_LATENCY      = xlat_pkg::DEF_READ_LATENCY
) (
   input  logic                                clk,
   input  logic                                reset,

   // --------------------------------------------------
   // system side
   // --------------------------------------------------
   input  logic [xlat_pkg::UAV_ADDR_W-1:0]     uav_address,
   input  logic [xlat_pkg::UAV_DATA_W-1:0]     uav_writedata,
   input  logic [xlat_pkg::BYTES_PER_WORD-1:0] uav_byteenable,
   input  logic                                uav_read,
   input  logic                                uav_write,
   output logic [xlat_pkg::UAV_DATA_W-1:0]     uav_readdata,
   output logic                                uav_readdatavalid,
   output logic                                uav_waitrequest,

   // --------------------------------------------------
   // peripheral side
   // --------------------------------------------------
   output logic [xlat_pkg::AV_ADDR_W-1:0]      av_address,
   output logic [xlat_pkg::UAV_DATA_W-1:0]     av_writedata,
   output logic [xlat_pkg::BYTES_PER_WORD-1:0] av_byteenable,
   output logic [xlat_pkg::BYTES_PER_WORD-1:0] av_writebyteenable,
   output logic                                av_read,
   output logic                                av_write,
   output logic                                av_begintransfer,
   output logic                                av_chipselect,
   input  logic [xlat_pkg::UAV_DATA_W-1:0]     av_readdata
);

   import xlat_pkg::*;

   logic read_accept;   // accept cycle of a read

   // address and byte lanes
   assign av_address         = uav_address[WORD_SHIFT +: AV_ADDR_W];   // byte to word
   assign av_writedata       = uav_writedata;
   assign av_byteenable      = uav_byteenable;
   assign av_writebyteenable = {BYTES_PER_WORD{uav_write}} & uav_byteenable;
   assign av_chipselect      = uav_read | uav_write;   // plain level, no extension

   assign uav_readdata = av_readdata;   // peripheral times its own data

   // --------------------------------------------------
   // strobe and waitrequest generation
   // --------------------------------------------------
   wait_state_seq #(
      .SETUP_CYCLES     (SETUP_CYCLES),
      .READ_WAIT_CYCLES (READ_WAIT_CYCLES),
      .WRITE_WAIT_CYCLES(WRITE_WAIT_CYCLES),
      .HOLD_CYCLES      (HOLD_CYCLES)
   ) u_seq (
      .clk             (clk),
      .reset           (reset),
      .uav_read        (uav_read),
      .uav_write       (uav_write),
      .av_read         (av_read),
      .av_write        (av_write),
      .av_begintransfer(av_begintransfer),
      .uav_waitrequest (uav_waitrequest),
      .read_accept     (read_accept)
   );

   // fixed latency readdatavalid
   read_valid_pipe #(
      .READ_LATENCY(READ_LATENCY)
   ) u_rd_pipe (
      .clk              (clk),
      .reset            (reset),
      .read_accept      (read_accept),
      .uav_readdatavalid(uav_readdatavalid)
   );

   // --------------------------------------------------
   // master protocol checks
   // --------------------------------------------------
   a_word_aligned: assert property (
      @(posedge clk) disable iff (reset)
      (uav_read || uav_write) |-> (uav_address[WORD_SHIFT-1:0] == '0)
   ) else $error("unaligned address %h", uav_address);

   a_one_request: assert property (
      @(posedge clk) disable iff (reset)
      !(uav_read && uav_write)
   ) else $error("read and write requested together");

endmodule : slave_xlat

`default_nettype wire

/* logic/read_valid_pipe.sv */
// delay line in the bridge top that marks read data valid READ_LATENCY cycles after accept
`timescale 1ns/1ns
`default_nettype none

module read_valid_pipe #(
   parameter int READ_LATENCY = xlat_pkg::DEF_READ_LATENCY   // at least one
) (
   input  logic clk,
   input  logic reset,

   input  logic read_accept,         // one cycle per accepted read
   output logic uav_readdatavalid
);

   // --------------------------------------------------
   // latency shift register
   // --------------------------------------------------
   // one bit per cycle of latency, so a new read can enter every
   // cycle while older ones are still on their way out
   logic [READ_LATENCY-1:0] pipe;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         pipe <= '0;
      end else begin
         pipe[0] <= read_accept;
         for (int i = 1; i < READ_LATENCY; i++) begin
            pipe[i] <= pipe[i-1];
         end
      end
   end

   assign uav_readdatavalid = pipe[READ_LATENCY-1];   // last stage

   // --------------------------------------------------
   // checks
   // --------------------------------------------------
   // each accepted read comes back at the fixed latency
   a_valid_after_accept: assert property (
      @(posedge clk) disable iff (reset)
      read_accept |-> ##READ_LATENCY uav_readdatavalid
   ) else $error("read accepted but no valid after %0d cycles", READ_LATENCY);

endmodule : read_valid_pipe

`default_nettype wire

/* logic/wait_state_seq.sv */
// wait-state sequencer: counts cycles per transfer and drives peripheral strobes and waitrequest
`timescale 1ns/1ns
`default_nettype none

module wait_state_seq #(
   parameter int SETUP_CYCLES      = xlat_pkg::DEF_SETUP_CYCLES,
   parameter int READ_WAIT_CYCLES  = xlat_pkg::DEF_READ_WAIT_CYCLES,
   parameter int WRITE_WAIT_CYCLES = xlat_pkg::DEF_WRITE_WAIT_CYCLES,
   parameter int HOLD_CYCLES       = xlat_pkg::DEF_HOLD_CYCLES
) (
   input  logic clk,
   input  logic reset,

   // system side request levels
   input  logic uav_read,
   input  logic uav_write,

   // peripheral strobes
   output logic av_read,
   output logic av_write,
   output logic av_begintransfer,

   // back to the master and the read pipe
   output logic uav_waitrequest,
   output logic read_accept
);

   import xlat_pkg::*;

   // --------------------------------------------------
   // counter values that mark phase boundaries
   // --------------------------------------------------
   localparam logic [CNT_W-1:0] SETUP_END =
      CNT_W'(SETUP_CYCLES);                                   // first access cycle
   localparam logic [CNT_W-1:0] READ_IDX =
      CNT_W'(SETUP_CYCLES + READ_WAIT_CYCLES);                // read accept cycle
   localparam logic [CNT_W-1:0] WRITE_IDX =
      CNT_W'(SETUP_CYCLES + WRITE_WAIT_CYCLES);               // last write strobe cycle
   localparam logic [CNT_W-1:0] HOLD_IDX =
      CNT_W'(SETUP_CYCLES + WRITE_WAIT_CYCLES + HOLD_CYCLES); // write accept cycle

   logic [CNT_W-1:0] wait_cnt;
   logic [CNT_W-1:0] cnt_inc;
   xfer_phase_e      phase;         // registered phase, PH_IDLE in cycle 0
   xfer_phase_e      cur_phase;
   logic             reset_override;
   logic             begun;         // begintransfer already issued
   logic             req;
   logic             wait_gen;
   logic             accept;

   // phase that a given count falls in, for the current kind of request
   function automatic xfer_phase_e phase_at(input logic [CNT_W-1:0] c, input logic wr);
      logic [CNT_W-1:0] last_access;
      last_access = wr ? WRITE_IDX : READ_IDX;
      if (c < SETUP_END) begin
         return PH_SETUP;
      end else if (c <= last_access) begin
         return PH_ACCESS;
      end
      return PH_HOLD;   // only reachable on writes
   endfunction

   assign req     = uav_read | uav_write;
   assign cnt_inc = wait_cnt + 1'b1;

   // --------------------------------------------------
   // phase decode
   // --------------------------------------------------
   // the register restarts at PH_IDLE, so cycle 0 is decoded straight
   // from the counter, which matters when SETUP_CYCLES is zero
   always_comb begin
      if (!req) begin
         cur_phase = PH_IDLE;
      end else if (phase == PH_IDLE) begin
         cur_phase = phase_at(wait_cnt, uav_write);
      end else begin
         cur_phase = phase;
      end
   end

   assign av_read  = uav_read & (cur_phase == PH_ACCESS);
   assign av_write = uav_write & (cur_phase == PH_ACCESS);

   // --------------------------------------------------
   // waitrequest generation
   // --------------------------------------------------
   always_comb begin
      if (uav_write) begin
         wait_gen = (wait_cnt != HOLD_IDX);
      end else if (uav_read) begin
         wait_gen = (wait_cnt != READ_IDX);
      end else begin
         wait_gen = 1'b1;   // idle, nothing to accept
      end
   end

   assign uav_waitrequest = wait_gen | reset_override;
   assign accept          = req & ~uav_waitrequest;
   assign read_accept     = uav_read & ~uav_waitrequest;

   // counter and phase, cleared on every accept
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         reset_override <= 1'b1;
         wait_cnt       <= '0;
         phase          <= PH_IDLE;
      end else begin
         reset_override <= 1'b0;   // high for one cycle only
         if (accept || !req || reset_override) begin
            wait_cnt <= '0;
            phase    <= PH_IDLE;
         end else begin
            wait_cnt <= cnt_inc;
            phase    <= phase_at(cnt_inc, uav_write);
         end
      end
   end

   // --------------------------------------------------
   // begintransfer, first cycle of each transfer
   // --------------------------------------------------
   assign av_begintransfer = req & ~begun;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         begun <= 1'b0;
      end else if (!uav_waitrequest || !req) begin
         begun <= 1'b0;   // transfer done or dropped
      end else if (av_begintransfer && !reset_override) begin
         begun <= 1'b1;
      end
   end

   // a new request after an accept must start again from cycle 0
   a_restart_after_accept: assert property (
      @(posedge clk) disable iff (reset)
      (req && !uav_waitrequest) |=> (!(uav_read || uav_write) || wait_cnt == '0)
   ) else $error("wait counter not cleared after accept");

endmodule : wait_state_seq

`default_nettype wire

/* common/xlat_pkg.sv */
// shared widths, default timing and sequencer phase type for the bus-to-peripheral bridge
`default_nettype none

package xlat_pkg;

   // --------------------------------------------------
   // bus widths
   // --------------------------------------------------
   localparam int UAV_ADDR_W     = 32;   // byte address, system side
   localparam int UAV_DATA_W     = 32;   // same width on both sides
   localparam int BYTES_PER_WORD = 4;    // also the byteenable width
   localparam int WORD_SHIFT     = 2;    // log2 of BYTES_PER_WORD
   localparam int AV_ADDR_W      = 30;   // word address, peripheral side

   // --------------------------------------------------
   // default peripheral timing, in clock cycles
   // --------------------------------------------------
   localparam int DEF_SETUP_CYCLES      = 1;
   localparam int DEF_READ_WAIT_CYCLES  = 2;
   localparam int DEF_WRITE_WAIT_CYCLES = 1;
   localparam int DEF_HOLD_CYCLES       = 1;   // data held after write strobe drops
   localparam int DEF_READ_LATENCY      = 2;   // accept edge to valid data

   // wait counter, enough for a transfer of up to 15 cycles
   localparam int CNT_W = 4;

   // --------------------------------------------------
   // sequencer phase
   // --------------------------------------------------
   typedef enum logic [1:0] {
      PH_IDLE   = 2'd0,   // no transfer started
      PH_SETUP  = 2'd1,   // address out, strobe still low
      PH_ACCESS = 2'd2,   // read or write strobe high
      PH_HOLD   = 2'd3    // write only, data held after the strobe
   } xfer_phase_e;

endpackage : xlat_pkg

`default_nettype wire
